/* rtl/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    // Branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // Load/store access size, U for zero extension
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

endpackage

`default_nettype wire

/* rtl/coreCtrlPkg.sv */
`default_nettype none

package coreCtrlPkg;

    localparam int aluOpW = 4;
    localparam int beW    = 4;

    // Low three bits follow funct3
    localparam logic [aluOpW-1:0] aluAdd  = 4'b0000;
    localparam logic [aluOpW-1:0] aluSll  = 4'b0001;
    localparam logic [aluOpW-1:0] aluSlt  = 4'b0010;
    localparam logic [aluOpW-1:0] aluSltu = 4'b0011;
    localparam logic [aluOpW-1:0] aluXor  = 4'b0100;
    localparam logic [aluOpW-1:0] aluSrl  = 4'b0101;
    localparam logic [aluOpW-1:0] aluOr   = 4'b0110;
    localparam logic [aluOpW-1:0] aluAnd  = 4'b0111;
    localparam logic [aluOpW-1:0] aluSub  = 4'b1000; // funct7 bit 5 set
    localparam logic [aluOpW-1:0] aluSra  = 4'b1101;

    // Branch comparisons
    localparam logic [aluOpW-1:0] brEq  = 4'b1001;
    localparam logic [aluOpW-1:0] brNe  = 4'b1010;
    localparam logic [aluOpW-1:0] brLt  = 4'b1011;
    localparam logic [aluOpW-1:0] brGe  = 4'b1100;
    localparam logic [aluOpW-1:0] brLtu = 4'b1110;
    localparam logic [aluOpW-1:0] brGeu = 4'b1111;

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
`default_nettype none

module instrDecoder (
    input  wire  [rvIsaPkg::xlen-1:0]      instr,
    output logic [rvIsaPkg::xlen-1:0]      imm,
    output logic [rvIsaPkg::regAddrW-1:0]  rs1,
    output logic [rvIsaPkg::regAddrW-1:0]  rs2,
    output logic [rvIsaPkg::regAddrW-1:0]  rd,
    output logic [coreCtrlPkg::aluOpW-1:0] aluOp,
    output logic [2:0]                     loadFunct,
    output logic [coreCtrlPkg::beW-1:0]    storeBe,
    output logic                           rfWe,
    output logic                           storeN,
    output logic                           noRs1,
    output logic                           isItype,
    output logic                           isAuipc,
    output logic                           isLoad,
    output logic                           isJal,
    output logic                           isJalr,
    output logic                           isBranch
);
    import rvIsaPkg::*;
    import coreCtrlPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Every format extends from instr[31]
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        imm       = '0;
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        aluOp     = aluAdd;
        loadFunct = '0;
        storeBe   = '0;
        rfWe      = 1'b0;
        storeN    = 1'b1;
        noRs1     = 1'b0;
        isItype   = 1'b0;
        isAuipc   = 1'b0;
        isLoad    = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        isBranch  = 1'b0;
        case (opcode)
            opLui, opAuipc:
            begin
                imm     = immU;
                rd      = instr[11:7];
                rfWe    = 1'b1;
                noRs1   = 1'b1;
                isItype = 1'b1;
                isAuipc = (opcode == opAuipc); // PC replaces rs1
            end
            opJal:
            begin
                imm     = immJ;
                rd      = instr[11:7];
                rfWe    = 1'b1;
                noRs1   = 1'b1;
                isItype = 1'b1;
                isJal   = 1'b1;
            end
            opJalr:
            begin
                imm     = immI;
                rs1     = instr[19:15];
                rd      = instr[11:7];
                rfWe    = 1'b1;
                isItype = 1'b1;
                isJalr  = 1'b1;
            end
            opBranch:
            begin
                imm      = immB;
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                isBranch = 1'b1;
                case (funct3)
                    f3Beq:   aluOp = brEq;
                    f3Bne:   aluOp = brNe;
                    f3Blt:   aluOp = brLt;
                    f3Bge:   aluOp = brGe;
                    f3Bltu:  aluOp = brLtu;
                    f3Bgeu:  aluOp = brGeu;
                    default: isBranch = 1'b0;
                endcase
            end
            opLoad:
            begin
                imm       = immI;
                rs1       = instr[19:15];
                rd        = instr[11:7];
                rfWe      = 1'b1;
                isItype   = 1'b1;
                isLoad    = 1'b1;
                loadFunct = funct3;
            end
            opStore:
            begin
                imm     = immS;
                rs1     = instr[19:15];
                rs2     = instr[24:20];
                isItype = 1'b1;
                // Unaligned enables, the aligner shifts them
                case (funct3)
                    f3Byte:  storeBe = 4'b0001;
                    f3Half:  storeBe = 4'b0011;
                    f3Word:  storeBe = 4'b1111;
                    default: storeBe = 4'b0000;
                endcase
                storeN = funct3[2] || (funct3[1:0] == 2'b11); // Only SB, SH and SW
            end
            opImm:
            begin
                imm     = immI;
                rs1     = instr[19:15];
                rd      = instr[11:7];
                rfWe    = 1'b1;
                isItype = 1'b1;
                aluOp   = {(funct3 == 3'b101) && instr[30], funct3}; // SRAI only
            end
            opReg:
            begin
                rs1   = instr[19:15];
                rs2   = instr[24:20];
                rd    = instr[11:7];
                rfWe  = 1'b1;
                aluOp = {instr[30], funct3};
            end
            default:
            begin
                rfWe = 1'b0; // Unknown opcode, no side effects
            end
        endcase
    end

    always_comb
    begin
        if (!storeN)
        begin
            assert final (storeBe != '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`default_nettype none

module regFile (
    input  wire         clk,
    input  wire         arstN,
    input  wire  [4:0]  rs1,
    input  wire  [4:0]  rs2,
    input  wire  [4:0]  rd,
    input  wire         we,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (rd != 5'd0)) // x0 never written
        begin
            regs[rd] <= wdata;
        end
    end

    // Combinational read, a same-edge write shows next cycle
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 holds zero across every write the core issues
    x0Zero: assert property (@(posedge clk) disable iff (!arstN) regs[0] == 32'd0);

endmodule

`default_nettype wire

/* rtl/aluUnit.sv */
`default_nettype none

module aluUnit (
    input  wire  [31:0]                    opA,
    input  wire  [31:0]                    opB,
    input  wire  [coreCtrlPkg::aluOpW-1:0] aluOp,
    output logic [31:0]                    result,
    output logic                           branchTaken
);
    import coreCtrlPkg::*;

    logic [4:0] shamt;
    logic       isEqual;
    logic       signedLt;
    logic       unsignedLt;

    assign shamt      = opB[4:0];
    assign isEqual    = (opA == opB);
    assign signedLt   = ($signed(opA) < $signed(opB));
    assign unsignedLt = (opA < opB);

    always_comb
    begin
        result      = '0;
        branchTaken = 1'b0;
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluSll:  result = opA << shamt;
            aluSlt:  result = {31'd0, signedLt};
            aluSltu: result = {31'd0, unsignedLt};
            aluXor:  result = opA ^ opB;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $unsigned($signed(opA) >>> shamt); // Keeps the sign
            aluOr:   result = opA | opB;
            aluAnd:  result = opA & opB;
            // Branch codes leave result at zero
            brEq:    branchTaken = isEqual;
            brNe:    branchTaken = !isEqual;
            brLt:    branchTaken = signedLt;
            brGe:    branchTaken = !signedLt;
            brLtu:   branchTaken = unsignedLt;
            brGeu:   branchTaken = !unsignedLt;
            default:
            begin
                result      = '0;
                branchTaken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/loadStoreAlign.sv */
`default_nettype none

module loadStoreAlign (
    input  wire  [1:0]                   addrLow,
    input  wire  [2:0]                   funct,
    input  wire  [coreCtrlPkg::beW-1:0]  storeBe,
    input  wire  [rvIsaPkg::xlen-1:0]    storeData,
    input  wire  [rvIsaPkg::xlen-1:0]    memRdata,
    output logic [rvIsaPkg::xlen-1:0]    memWdata,
    output logic [coreCtrlPkg::beW-1:0]  memBe,
    output logic [rvIsaPkg::xlen-1:0]    loadData
);
    import rvIsaPkg::*;

    logic [xlen-1:0] rdShifted;
    logic            halfAccess;

    // Byte lane from the address low bits
    assign memWdata  = storeData << {addrLow, 3'b000};
    assign memBe     = storeBe << addrLow;
    assign rdShifted = memRdata >> {addrLow, 3'b000};

    always_comb
    begin
        case (funct)
            f3Byte:  loadData = {{24{rdShifted[7]}}, rdShifted[7:0]};
            f3ByteU: loadData = {24'd0, rdShifted[7:0]};
            f3Half:  loadData = {{16{rdShifted[15]}}, rdShifted[15:0]};
            f3HalfU: loadData = {16'd0, rdShifted[15:0]};
            default: loadData = rdShifted; // Word
        endcase
    end

    assign halfAccess = (funct == f3Half) || (funct == f3HalfU) || (storeBe == 4'b0011);

    always_comb
    begin
        if (halfAccess)
        begin
            assert final (!addrLow[0]);
        end
    end

endmodule

`default_nettype wire

/* rtl/rv32Core.sv */
`default_nettype none

module rv32Core (
    input  wire                          clk,
    input  wire                          arstN,
    output logic [31:0]                  imemAddr,
    input  wire  [31:0]                  imemData,
    output logic [31:0]                  dMemAddr,
    output logic [31:0]                  dMemWdata,
    output logic [coreCtrlPkg::beW-1:0]  dMemBe,
    output logic                         dMemWen,
    input  wire  [31:0]                  dMemRdata
);
    import coreCtrlPkg::*;

    logic [31:0]       pc;
    logic [31:0]       pcPlus4;
    logic [31:0]       pcImm;
    logic [31:0]       nextPc;
    logic [31:0]       imm;
    logic [31:0]       rdata1;
    logic [31:0]       rdata2;
    logic [31:0]       opA;
    logic [31:0]       opB;
    logic [31:0]       aluResult;
    logic [31:0]       loadData;
    logic [31:0]       wbData;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [aluOpW-1:0] aluOp;
    logic [2:0]        loadFunct;
    logic [beW-1:0]    storeBe;
    logic              rfWe;
    logic              storeN;
    logic              noRs1;
    logic              isItype;
    logic              isAuipc;
    logic              isLoad;
    logic              isJal;
    logic              isJalr;
    logic              isBranch;
    logic              branchTaken;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= nextPc;
        end
    end

    assign imemAddr = pc;
    assign pcPlus4  = pc + 32'd4;
    assign pcImm    = pc + imm;

    always_comb
    begin
        if (isJalr)
        begin
            nextPc = {aluResult[31:1], 1'b0};
        end
        else if (isJal || (isBranch && branchTaken))
        begin
            nextPc = pcImm;
        end
        else
        begin
            nextPc = pcPlus4;
        end
    end

    instrDecoder instrDecoder_inst (
        .instr     (imemData),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .aluOp     (aluOp),
        .loadFunct (loadFunct),
        .storeBe   (storeBe),
        .rfWe      (rfWe),
        .storeN    (storeN),
        .noRs1     (noRs1),
        .isItype   (isItype),
        .isAuipc   (isAuipc),
        .isLoad    (isLoad),
        .isJal     (isJal),
        .isJalr    (isJalr),
        .isBranch  (isBranch)
    );

    regFile regFile_inst (
        .clk    (clk),
        .arstN  (arstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (rfWe),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // AUIPC and JAL add to the PC, LUI adds to zero
    assign opA = (isAuipc || isJal) ? pc : (noRs1 ? 32'd0 : rdata1);
    assign opB = isItype ? imm : rdata2;

    aluUnit aluUnit_inst (
        .opA         (opA),
        .opB         (opB),
        .aluOp       (aluOp),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    loadStoreAlign loadStoreAlign_inst (
        .addrLow   (aluResult[1:0]),
        .funct     (loadFunct),
        .storeBe   (storeBe),
        .storeData (rdata2),
        .memRdata  (dMemRdata),
        .memWdata  (dMemWdata),
        .memBe     (dMemBe),
        .loadData  (loadData)
    );

    assign dMemAddr = aluResult;
    assign dMemWen  = storeN | ~arstN; // No store commits while in reset

    assign wbData = isLoad ? loadData : ((isJal || isJalr) ? pcPlus4 : aluResult);

endmodule

`default_nettype wire

/* testbench/rv32CoreTb.sv */
`default_nettype none

module rv32CoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        arstN;
    wire  [31:0] imemAddr;
    wire  [31:0] imemData;
    wire  [31:0] dMemAddr;
    wire  [31:0] dMemWdata;
    wire  [3:0]  dMemBe;
    wire         dMemWen;
    wire  [31:0] dMemRdata;

    logic [31:0] golden [512];
    logic [31:0] imem [256];
    logic [31:0] dmem [1024]; // 4 KB

    int progWords;
    int storeCount;
    int storeIdx;
    int cycles;
    int limit;

    rv32Core rv32Core_inst (
        .clk       (clk),
        .arstN     (arstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dMemAddr  (dMemAddr),
        .dMemWdata (dMemWdata),
        .dMemBe    (dMemBe),
        .dMemWen   (dMemWen),
        .dMemRdata (dMemRdata)
    );

    // Both memories answer in the same cycle
    assign imemData  = imem[imemAddr[9:2]];
    assign dMemRdata = dmem[dMemAddr[11:2]];

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] byteMask(input logic [3:0] be);
        byteMask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // Store monitor and data memory write port
    always @(posedge clk)
    begin
        int base;
        if (arstN && !dMemWen)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (dMemBe[b])
                begin
                    dmem[dMemAddr[11:2]][8*b +: 8] <= dMemWdata[8*b +: 8];
                end
            end
            if (storeIdx >= storeCount)
            begin
                $display("Unexpected store to address 0x%08h after the last expected one",
                         dMemAddr);
                $display("=== FAIL ===");
                $fatal(1);
            end
            base = 2 + progWords + 3 * storeIdx;
            checkEq("dMemAddr", dMemAddr, golden[base]);
            checkEq("dMemBe", {28'd0, dMemBe}, golden[base + 2]);
            checkEq("dMemWdata", dMemWdata & byteMask(dMemBe), golden[base + 1]);
            storeIdx = storeIdx + 1;
        end
    end

    initial
    begin
        arstN    = 1'b0;
        storeIdx = 0;
        cycles   = 0;
        for (int i = 0; i < 512; i++)
        begin
            golden[i] = 32'd0;
        end
        $readmemh("testbench/core_golden.mem", golden);
        progWords  = golden[0];
        storeCount = golden[1];
        limit      = 8 * progWords + 50;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = (i < progWords) ? golden[2 + i] : 32'h0000_0013; // NOP fill
        end
        for (int i = 0; i < 1024; i++)
        begin
            dmem[i] = 32'd0;
        end

        repeat (4) @(posedge clk);
        checkEq("imemAddr", imemAddr, 32'd0); // Fetch starts at the reset vector
        arstN <= 1'b1;

        while ((storeIdx < storeCount) && (cycles < limit))
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end

        if (storeIdx == storeCount)
        begin
            repeat (10) @(posedge clk); // Catch stray stores
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, storeIdx, storeCount);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* testbench/core_golden.mem */
// Word 0 program word count, word 1 store count, then the program words,
// then one store record per line: address, data masked by byte enable, byte enable
00000053 0000001a
00500093 ffd00113 002081b3 10302023 40110233 10402223 40125293 10502423
40125333 001253b3 00112433 001134b3 10602623 10702823 10802a23 10902c23
0f014513 00409593 00b56633 07f67693 10c02e23 12d02023 12345737 00001797
12e02223 12f02423 00108463 10080813 00209463 10080813 00114463 10080813
0020d463 10080813 0020e463 10080813 00117463 10080813 00208463 00180813
00109463 00280813 0020c463 00480813 00115463 00880813 00116463 01080813
0020f463 02080813 00300893 01190933 fff88893 fe089ce3 13002623 13202823
008009ef 00100a13 00000a97 00da8b67 00100a13 13302a23 13402c23 13602e23
8899bc37 abbc0c13 218000a3 21801323 21802423 218001a3 20900c83 20b04d03
20a01d83 20805e03 20002e83 15902023 15a02223 15b02423 15c02623 15d02823
00700013 14002a23 0000006f
00000100 00000002 0000000f
00000104 fffffff8 0000000f
00000108 fffffffc 0000000f
0000010c ffffffff 0000000f
00000110 07ffffff 0000000f
00000114 00000001 0000000f
00000118 00000000 0000000f
0000011c ffffff5d 0000000f
00000120 0000005d 0000000f
00000124 12345000 0000000f
00000128 0000105c 0000000f
0000012c 0000003f 0000000f
00000130 00000006 0000000f
00000134 000000e4 0000000f
00000138 00000000 0000000f
0000013c 000000f0 0000000f
00000201 0000bb00 00000002
00000206 aabb0000 0000000c
00000208 8899aabb 0000000f
00000203 bb000000 00000008
00000140 ffffffaa 0000000f
00000144 00000088 0000000f
00000148 ffff8899 0000000f
0000014c 0000aabb 0000000f
00000150 bb00bb00 0000000f
00000154 00000000 0000000f

/* project.f */
rtl/rvIsaPkg.sv
rtl/coreCtrlPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/loadStoreAlign.sv
rtl/rv32Core.sv
testbench/rv32CoreTb.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary -f project.f --top-module rv32CoreTb -o rv32CoreTb
./obj_dir/rv32CoreTb | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
